// ==== Makefile ====
# Verilator build and run for the console glue testbench

VERILATOR ?= verilator
TOP       ?= tb_sms_glue
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, the simulator status is not trusted alone
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_sms_glue_checks.svh ====
/*
 * Console glue testbench helpers
 * Reference models for strobes, ROM folding and the SD load pattern,
 * plus typed compare tasks that stop the run at the first error
 */

`ifndef TB_SMS_GLUE_CHECKS_SVH
`define TB_SMS_GLUE_CHECKS_SVH

// ============================================================================
// Reference functions
// ============================================================================

// Strobes for one divider phase as {cpu, vdp, pix, sp}
function automatic logic [3:0] ce_expect(int phase);
	return {phase == 9 || phase == 24, phase % 5 == 4, phase % 10 == 9, phase % 2 == 1};
endfunction

// Console read address folded into an image of image_bytes (power of two)
function automatic rom_addr_t fold_expect(rom_addr_t rd, int image_bytes, logic header);
	rom_addr_t mask;
	mask = rom_addr_t'(image_bytes - 1);
	if (header)
		return (rd + rom_addr_t'(HEADER_BYTES)) & mask;  // Skip the dump header
	return rd & mask;
endfunction

// Byte the SD model delivers for each backup RAM address
function automatic byte_t load_pattern(nvram_addr_t a);
	return byte_t'(a[7:0] * 8'd3) ^ a[14:7] ^ 8'hA5;
endfunction

// ============================================================================
// Compare tasks
// ============================================================================
task automatic stop_with_error(string what);
	$display("%s", what);
	$display("Simulation FAILED");
	$fatal(1, "Stopped at first error");
endtask

task automatic check_bit(string name, logic got, logic want);
	if (got !== want)
		stop_with_error($sformatf("Mismatch at %0t: %s got %b expected %b",
			$time, name, got, want));
endtask

task automatic check_byte(string name, byte_t got, byte_t want);
	if (got !== want)
		stop_with_error($sformatf("Mismatch at %0t: %s got 0x%02h expected 0x%02h",
			$time, name, got, want));
endtask

task automatic check_rom_addr(string name, rom_addr_t got, rom_addr_t want);
	if (got !== want)
		stop_with_error($sformatf("Mismatch at %0t: %s got 0x%06h expected 0x%06h",
			$time, name, got, want));
endtask

task automatic check_sector(string name, sector_t got, sector_t want);
	if (got !== want)
		stop_with_error($sformatf("Mismatch at %0t: %s got %0d expected %0d",
			$time, name, got, want));
endtask

`endif

// ==== verification/tb_sms_glue.sv ====
/*
 * Console glue testbench
 * Clock enables, ROM download with a toggle-ack memory model, address
 * folding, backup RAM save and automatic load through an SD host model
 */

`timescale 1ns/1ps

module tb_sms_glue;
	import sms_glue_pkg::*;

	localparam int ROM_A_BYTES   = 16384;
	localparam int ROM_B_BYTES   = 16384 + HEADER_BYTES;
	localparam int ROM_C_BYTES   = 2048;
	localparam int NV_BYTES      = 1 << $bits(nvram_addr_t);
	localparam int SECTOR_CYCLES = 600;
	localparam int WATCHDOG_CYCLES = (ROM_A_BYTES + ROM_B_BYTES + ROM_C_BYTES) * 8
		+ 2 * BK_SECTORS * SECTOR_CYCLES + 3 * NV_BYTES + 20000;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        ioctl_download, ioctl_wr, ioctl_wait;
	ioctl_addr_t ioctl_addr;
	byte_t       ioctl_dout, ioctl_index, rom_wr_data;
	rom_addr_t   rom_wr_addr, rom_rd_addr, mem_rd_addr;
	logic        rom_wr_req, rom_wr_ack, gg;
	logic        bk_load, bk_save, img_mounted, img_readonly;
	logic [63:0] img_size;
	sector_t     sd_lba;
	logic        sd_rd, sd_wr, sd_ack, sd_buff_wr;
	buff_addr_t  sd_buff_addr;
	byte_t       sd_buff_dout, sd_buff_din;
	logic        bk_ena, bk_busy, bk_loading;
	nvram_addr_t nvram_a;
	logic        nvram_we;
	byte_t       nvram_d, nvram_q;
	logic        ce_cpu, ce_vdp, ce_pix, ce_sp;

	int        sectors_done;
	logic      load_mode;               // Transfer in progress is a load
	byte_t     sent_rom [0:ROM_B_BYTES-1];
	byte_t     rom_mem [rom_addr_t];    // External ROM memory contents
	byte_t     nv_exp [0:NV_BYTES-1];

	`include "tb_sms_glue_checks.svh"

	sms_glue_top UUT (.*);

	always #2 clk_sys = ~clk_sys;

	// ========================================================================
	// Memory and SD host models
	// ========================================================================
	initial begin : rom_memory_model
		forever begin
			@(negedge clk_sys);
			if (rst_n && (rom_wr_req != rom_wr_ack)) begin
				rom_mem[rom_wr_addr] = rom_wr_data;
				repeat ($urandom_range(6, 1)) @(negedge clk_sys);
				rom_wr_ack = rom_wr_req;
			end
		end
	end

	task automatic serve_sector(sector_t lba, logic reading);
		nvram_addr_t nv;
		sd_ack       = 1'b1;
		sd_buff_addr = '0;
		sd_buff_wr   = reading;
		sd_buff_dout = load_pattern({lba[5:0], 9'd0});
		for (int i = 1; i <= 512; i++) begin
			@(negedge clk_sys);
			check_bit("bk_loading", bk_loading, load_mode);
			if (!reading) begin
				nv = {lba[5:0], buff_addr_t'(i - 1)};  // Byte addressed last cycle
				check_byte($sformatf("sd_buff_din[%0d]", nv), sd_buff_din, nv_exp[nv]);
			end
			if (i < 512) begin
				sd_buff_addr = buff_addr_t'(i);
				sd_buff_dout = load_pattern({lba[5:0], buff_addr_t'(i)});
			end else begin
				sd_buff_wr = 1'b0;
			end
		end
		@(negedge clk_sys);
		check_bit("bk_loading", bk_loading, load_mode);
		sd_ack = 1'b0;
	endtask

	initial begin : sd_host_model
		sector_t lba;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				lba = sd_lba;
				check_sector("sd_lba", lba, sector_t'(sectors_done));
				check_bit("sd_rd", sd_rd, load_mode);
				check_bit("bk_loading", bk_loading, load_mode);
				serve_sector(lba, sd_rd);
				sectors_done = sectors_done + 1;
				if (lba == sector_t'(BK_SECTORS - 1)) begin
					@(negedge clk_sys);
					check_bit("bk_busy", bk_busy, 1'b0);  // One cycle after last ack
					check_bit("bk_loading", bk_loading, 1'b0);
				end
			end else begin
				check_bit("bk_loading", bk_loading, 1'b0);  // No transfer running
			end
		end
	end

	// ========================================================================
	// Monitors
	// ========================================================================
	initial begin : ce_monitor
		int         phase;
		logic [3:0] want;
		phase = 0;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk_sys);
			want = ce_expect(phase);
			check_bit("ce_cpu", ce_cpu, want[3]);
			check_bit("ce_vdp", ce_vdp, want[2]);
			check_bit("ce_pix", ce_pix, want[1]);
			check_bit("ce_sp", ce_sp, want[0]);
			if (phase == CE_PERIOD - 1)
				phase = 0;
			else
				phase = phase + 1;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		stop_with_error($sformatf("Watchdog timeout after %0d cycles", WATCHDOG_CYCLES));
	end

	// ========================================================================
	// Stimulus tasks
	// ========================================================================
	task automatic load_rom(byte_t index, int bytes);
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		repeat (3) @(negedge clk_sys);  // Let download_start clear the address
		for (int i = 0; i < bytes; i++) begin
			if (ioctl_wait)
				stop_with_error("Host was about to send a byte while ioctl_wait is high");
			sent_rom[i] = byte_t'($urandom);
			ioctl_addr  = ioctl_addr_t'(i);
			ioctl_dout  = sent_rom[i];
			ioctl_wr    = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_bit("ioctl_wait", ioctl_wait, 1'b1);
			while (ioctl_wait)
				@(negedge clk_sys);
		end
		repeat (2) @(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	task automatic verify_rom(int bytes);
		rom_addr_t a;
		for (int i = 0; i < bytes; i++) begin
			a = rom_addr_t'(i);
			if (!rom_mem.exists(a))
				stop_with_error($sformatf("No ROM write reached address %0d", i));
			check_byte($sformatf("rom_mem[%0d]", i), rom_mem[a], sent_rom[i]);
		end
	endtask

	task automatic check_folding(int image_bytes, logic header);
		rom_addr_t rd;
		for (int i = 0; i < 64; i++) begin
			@(negedge clk_sys);
			rd          = rom_addr_t'($urandom);
			rom_rd_addr = rd;
			#1;
			check_rom_addr("mem_rd_addr", mem_rd_addr, fold_expect(rd, image_bytes, header));
		end
	endtask

	task automatic fill_nvram();
		for (int i = 0; i < NV_BYTES; i++) begin
			@(negedge clk_sys);
			nv_exp[i] = byte_t'($urandom);
			nvram_a   = nvram_addr_t'(i);
			nvram_d   = nv_exp[i];
			nvram_we  = 1'b1;
		end
		@(negedge clk_sys);
		nvram_we = 1'b0;
	endtask

	task automatic verify_nvram_load();
		for (int i = 0; i <= NV_BYTES; i++) begin
			@(negedge clk_sys);
			if (i > 0)
				check_byte($sformatf("nvram_q[%0d]", i - 1), nvram_q,
					load_pattern(nvram_addr_t'(i - 1)));
			if (i < NV_BYTES)
				nvram_a = nvram_addr_t'(i);
		end
	endtask

	task automatic wait_idle(int limit);
		int n;
		n = 0;
		while (bk_busy) begin
			@(negedge clk_sys);
			n = n + 1;
			if (n > limit)
				stop_with_error("Backup transfer did not finish in time");
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		void'($urandom(32'he53d_6e04));
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_index    = '0;
		rom_wr_ack     = 1'b0;
		rom_rd_addr    = '0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		img_mounted    = 1'b1;  // Writable save file from the start
		img_readonly   = 1'b0;
		img_size       = '0;
		sd_ack         = 1'b0;
		sd_buff_addr   = '0;
		sd_buff_dout   = '0;
		sd_buff_wr     = 1'b0;
		nvram_a        = '0;
		nvram_we       = 1'b0;
		nvram_d        = '0;
		load_mode      = 1'b0;
		sectors_done   = 0;

		repeat (7) @(negedge clk_sys);
		check_bit("ce_vdp", ce_vdp, 1'b0);
		check_bit("ce_cpu", ce_cpu, 1'b0);
		check_bit("ce_pix", ce_pix, 1'b0);
		check_bit("ce_sp", ce_sp, 1'b0);
		@(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("rom_wr_req", rom_wr_req, 1'b0);
		check_bit("sd_rd", sd_rd, 1'b0);
		check_bit("sd_wr", sd_wr, 1'b0);
		check_bit("bk_busy", bk_busy, 1'b0);

		// Plain 16 KB image
		load_rom(8'd1, ROM_A_BYTES);
		repeat (4) @(negedge clk_sys);
		verify_rom(ROM_A_BYTES);
		check_bit("gg", gg, 1'b0);
		check_folding(16384, 1'b0);

		// Handheld image behind a 512-byte header
		load_rom(byte_t'(GG_INDEX), ROM_B_BYTES);
		repeat (4) @(negedge clk_sys);
		verify_rom(ROM_B_BYTES);
		check_bit("gg", gg, 1'b1);
		check_folding(16384, 1'b1);
		check_bit("bk_ena", bk_ena, 1'b1);
		check_bit("bk_busy", bk_busy, 1'b0);  // Empty save file, no load

		// Save on menu request
		fill_nvram();
		@(negedge clk_sys);
		bk_save = 1'b1;
		@(negedge clk_sys);
		check_bit("bk_busy", bk_busy, 1'b1);
		check_bit("sd_wr", sd_wr, 1'b1);
		repeat (3) @(negedge clk_sys);
		bk_save = 1'b0;
		wait_idle(BK_SECTORS * SECTOR_CYCLES);
		check_byte("sectors saved", byte_t'(sectors_done), byte_t'(BK_SECTORS));

		// Automatic load at the end of a download
		load_mode    = 1'b1;
		sectors_done = 0;
		img_size     = 64'd32768;
		load_rom(8'd0, ROM_C_BYTES);
		repeat (2) @(negedge clk_sys);
		check_bit("bk_busy", bk_busy, 1'b1);
		check_bit("sd_rd", sd_rd, 1'b1);
		wait_idle(BK_SECTORS * SECTOR_CYCLES);
		check_byte("sectors loaded", byte_t'(sectors_done), byte_t'(BK_SECTORS));
		check_bit("gg", gg, 1'b0);
		verify_rom(ROM_C_BYTES);
		verify_nvram_load();

		repeat (4) @(negedge clk_sys);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verification
verilog/sms_glue_pkg.sv
verilog/ce_divider.sv
verilog/cart_loader.sv
verilog/bk_sync_fsm.sv
verilog/nvram_dpram.sv
verilog/sms_glue_top.sv
verification/tb_sms_glue.sv

// ==== verilog/bk_sync_fsm.sv ====
/*
 * Backup RAM transfer controller
 * Moves the 32 KB battery RAM image to or from the SD host, one sector
 * per acknowledge, on a menu request or after a cartridge download
 */

`timescale 1ns/1ps

module bk_sync_fsm (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  bk_load,
	input  logic                  bk_save,
	input  logic                  download_active,
	input  logic                  download_start,
	input  logic                  download_end,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic [63:0]           img_size,
	output sms_glue_pkg::sector_t sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	input  logic                  sd_ack,
	output logic                  bk_ena,
	output logic                  bk_busy,
	output logic                  bk_loading
);
	import sms_glue_pkg::*;

	bk_state_t state;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      load_req;
	logic      save_req;
	logic      load_edge;
	logic      save_edge;
	logic      auto_load;
	logic      ack_rise;
	logic      ack_fall;
	logic      last_sector;

	assign load_req  = bk_load & bk_ena;
	assign save_req  = bk_save & bk_ena;
	assign load_edge = load_req & ~old_load;
	assign save_edge = save_req & ~old_save;
	assign auto_load = download_end & (|img_size) & bk_ena;  // Save file present
	assign ack_rise  = sd_ack & ~old_ack;
	assign ack_fall  = ~sd_ack & old_ack;
	assign last_sector = (sd_lba == sector_t'(BK_SECTORS - 1));

	assign bk_busy    = (state != BK_IDLE);
	assign bk_loading = (state == BK_READ);

	// The save file is mounted by the end of the download
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			bk_ena <= 1'b0;
		else if (download_active && img_mounted && !img_readonly)
			bk_ena <= 1'b1;
		else if (download_start)
			bk_ena <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_ack  <= sd_ack;
		end
	end

	// ========================================================================
	// Sector sequencer
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state  <= BK_IDLE;
			sd_lba <= '0;
			sd_rd  <= 1'b0;
			sd_wr  <= 1'b0;
		end else begin
			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (auto_load || load_edge) begin
						state  <= BK_READ;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
					end else if (save_edge) begin
						state  <= BK_WRITE;
						sd_lba <= '0;
						sd_wr  <= 1'b1;
					end
				end
				BK_READ, BK_WRITE: begin
					if (ack_fall) begin
						if (last_sector) begin
							state <= BK_IDLE;  // Whole image moved
						end else begin
							sd_lba <= sd_lba + sector_t'(1);
							sd_rd  <= (state == BK_READ);
							sd_wr  <= (state == BK_WRITE);
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	a_one_request: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd_rd && sd_wr));

endmodule

// ==== verilog/cart_loader.sv ====
/*
 * Cartridge download sequencer
 * Writes each host byte to the ROM memory, learns the image mask and
 * header, and folds console ROM reads into the loaded image
 */

`timescale 1ns/1ps

module cart_loader (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  sms_glue_pkg::ioctl_addr_t ioctl_addr,
	input  sms_glue_pkg::byte_t     ioctl_dout,
	input  sms_glue_pkg::byte_t     ioctl_index,
	output logic                    ioctl_wait,
	output sms_glue_pkg::rom_addr_t rom_wr_addr,
	output sms_glue_pkg::byte_t     rom_wr_data,
	output logic                    rom_wr_req,
	input  logic                    rom_wr_ack,
	input  sms_glue_pkg::rom_addr_t rom_rd_addr,
	output sms_glue_pkg::rom_addr_t mem_rd_addr,
	output logic                    gg,
	output logic                    download_start,
	output logic                    download_end
);
	import sms_glue_pkg::*;

	logic      old_download;
	logic      byte_accept;
	rom_addr_t load_addr;
	rom_addr_t cart_mask;      // Mask of a plain image
	rom_addr_t cart_mask_hdr;  // Mask of an image behind a 512-byte header
	logic [9:0] end_low;       // Low bits of the address after the last byte
	logic      has_header;

	assign byte_accept = ioctl_wr & ioctl_download;
	assign load_addr   = ioctl_addr[$bits(rom_addr_t)-1:0];

	// Download edges, one cycle late
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			old_download   <= 1'b0;
			download_start <= 1'b0;
			download_end   <= 1'b0;
		end else begin
			old_download   <= ioctl_download;
			download_start <= ioctl_download & ~old_download;
			download_end   <= ~ioctl_download & old_download;
		end
	end

	// ========================================================================
	// Write path, toggle request and wait until the ack catches up
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_wait  <= 1'b0;
			rom_wr_req  <= 1'b0;
			rom_wr_addr <= '0;
		end else if (download_start) begin
			rom_wr_addr <= '0;
		end else if (byte_accept) begin
			ioctl_wait <= 1'b1;
			rom_wr_req <= ~rom_wr_req;
		end else if (ioctl_wait && (rom_wr_req == rom_wr_ack)) begin
			ioctl_wait  <= 1'b0;  // Memory done, next address
			rom_wr_addr <= rom_wr_addr + rom_addr_t'(1);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_accept)
			rom_wr_data <= ioctl_dout;
	end

	// ========================================================================
	// Image mask and header detection
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_mask     <= '0;
			cart_mask_hdr <= '0;
			end_low       <= '0;
			has_header    <= 1'b0;
			gg            <= 1'b0;
		end else begin
			if (byte_accept) begin
				cart_mask     <= cart_mask | load_addr;
				cart_mask_hdr <= cart_mask_hdr | (load_addr - rom_addr_t'(HEADER_BYTES));
				if (ioctl_addr == '0)
					cart_mask <= '0;  // First byte restarts the plain mask
				if (ioctl_addr == ioctl_addr_t'(HEADER_BYTES))
					cart_mask_hdr <= '0;
				end_low <= ioctl_addr[9:0] + 10'd1;
				gg      <= (ioctl_index == byte_t'(GG_INDEX));
			end
			// Odd multiple of 512 in the size means a header is present
			if (download_end)
				has_header <= end_low[9];
		end
	end

	// Read folding into the loaded image
	always_comb begin
		if (has_header)
			mem_rd_addr = (rom_rd_addr + rom_addr_t'(HEADER_BYTES)) & cart_mask_hdr;
		else
			mem_rd_addr = rom_rd_addr & cart_mask;
	end

	// The memory sees one address for the whole write
	a_wr_addr_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ioctl_wait && $past(ioctl_wait)) |-> $stable(rom_wr_addr));

endmodule

// ==== verilog/ce_divider.sv ====
/*
 * Clock-enable divider
 * Divide-by-30 phase counter decoded into CPU, VDP, pixel and sprite strobes
 */

`timescale 1ns/1ps

module ce_divider (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);
	import sms_glue_pkg::*;

	ce_phase_t phase;

	// Phase counter, wraps after CE_PERIOD cycles
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase == ce_phase_t'(CE_PERIOD - 1)) begin
			phase <= '0;
		end else begin
			phase <= phase + ce_phase_t'(1);
		end
	end

	// Strobes are registered from the current phase
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			ce_vdp <= CE_VDP_PHASES[phase];  // div5
			ce_pix <= CE_PIX_PHASES[phase];  // div10
			ce_cpu <= CE_CPU_PHASES[phase];  // div15
			ce_sp  <= phase[0];              // div2
		end
	end

	// Slower enables must land on a VDP slot
	a_cpu_on_vdp: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_cpu |-> ce_vdp);
	a_pix_on_vdp: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |-> ce_vdp);

endmodule

// ==== verilog/nvram_dpram.sv ====
/*
 * Backup RAM, 32 KB true dual port
 * Port A faces the console, port B the SD sector buffer
 */

`timescale 1ns/1ps

module nvram_dpram (
	input  logic                      clk_sys,
	input  sms_glue_pkg::nvram_addr_t a_addr,
	input  logic                      a_we,
	input  sms_glue_pkg::byte_t       a_d,
	output sms_glue_pkg::byte_t       a_q,
	input  sms_glue_pkg::nvram_addr_t b_addr,
	input  logic                      b_we,
	input  sms_glue_pkg::byte_t       b_d,
	output sms_glue_pkg::byte_t       b_q
);
	import sms_glue_pkg::*;

	byte_t mem [0:(1 << $bits(nvram_addr_t)) - 1];

	// Both ports read the old byte on a write, one cycle latency
	always_ff @(posedge clk_sys) begin
		if (a_we)
			mem[a_addr] <= a_d;
		if (b_we)
			mem[b_addr] <= b_d;  // SD side wins a same-address collision
		a_q <= mem[a_addr];
		b_q <= mem[b_addr];
	end

endmodule

// ==== verilog/sms_glue_pkg.sv ====
/*
 * Console glue shared definitions
 * Widths, clock-enable phase tables, loader and backup RAM constants
 */

package sms_glue_pkg;

	// ========================================================================
	// Data and address widths
	// ========================================================================
	typedef logic [7:0]  byte_t;        // Download, ROM and backup RAM byte
	typedef logic [24:0] ioctl_addr_t;  // Host download byte address
	typedef logic [21:0] rom_addr_t;    // Cartridge ROM address, memory side
	typedef logic [14:0] nvram_addr_t;  // 32 KB backup RAM
	typedef logic [8:0]  buff_addr_t;   // Byte inside one SD sector
	typedef logic [31:0] sector_t;      // SD sector number, low 6 bits used
	typedef logic [4:0]  ce_phase_t;    // Enable divider phase

	// Backup RAM transfer controller
	typedef enum logic [1:0] {
		BK_IDLE,
		BK_READ,
		BK_WRITE
	} bk_state_t;

	// ========================================================================
	// Clock enables
	// ========================================================================
	localparam int CE_PERIOD = 30;

	// One bit per phase, set where the strobe fires
	localparam logic [CE_PERIOD-1:0] CE_VDP_PHASES =
		(30'd1 << 4) | (30'd1 << 9) | (30'd1 << 14) |
		(30'd1 << 19) | (30'd1 << 24) | (30'd1 << 29);
	localparam logic [CE_PERIOD-1:0] CE_PIX_PHASES =
		(30'd1 << 9) | (30'd1 << 19) | (30'd1 << 29);
	localparam logic [CE_PERIOD-1:0] CE_CPU_PHASES =
		(30'd1 << 9) | (30'd1 << 24);  // Phase 24 suits the HCounter timing

	// ========================================================================
	// Cartridge loader and backup RAM
	// ========================================================================
	localparam int HEADER_BYTES = 512;  // Optional dump header
	localparam int BK_SECTORS   = 64;   // 64 x 512 bytes = 32 KB
	localparam int GG_INDEX     = 2;    // Download index of handheld images

endpackage

// ==== verilog/sms_glue_top.sv ====
/*
 * Console board glue, top level
 * Clock enables, cartridge download, ROM address folding and backup RAM
 */

`timescale 1ns/1ps

module sms_glue_top (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	// Host download stream
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  sms_glue_pkg::ioctl_addr_t ioctl_addr,
	input  sms_glue_pkg::byte_t       ioctl_dout,
	input  sms_glue_pkg::byte_t       ioctl_index,
	output logic                      ioctl_wait,
	// ROM memory
	output sms_glue_pkg::rom_addr_t   rom_wr_addr,
	output sms_glue_pkg::byte_t       rom_wr_data,
	output logic                      rom_wr_req,
	input  logic                      rom_wr_ack,
	input  sms_glue_pkg::rom_addr_t   rom_rd_addr,
	output sms_glue_pkg::rom_addr_t   mem_rd_addr,
	output logic                      gg,
	// Backup RAM control and SD host
	input  logic                      bk_load,
	input  logic                      bk_save,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [63:0]               img_size,
	output sms_glue_pkg::sector_t     sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	input  logic                      sd_ack,
	input  sms_glue_pkg::buff_addr_t  sd_buff_addr,
	input  sms_glue_pkg::byte_t       sd_buff_dout,
	output sms_glue_pkg::byte_t       sd_buff_din,
	input  logic                      sd_buff_wr,
	output logic                      bk_ena,
	output logic                      bk_busy,
	output logic                      bk_loading,
	// Console backup port
	input  sms_glue_pkg::nvram_addr_t nvram_a,
	input  logic                      nvram_we,
	input  sms_glue_pkg::byte_t       nvram_d,
	output sms_glue_pkg::byte_t       nvram_q,
	// Clock enables
	output logic                      ce_cpu,
	output logic                      ce_vdp,
	output logic                      ce_pix,
	output logic                      ce_sp
);
	import sms_glue_pkg::*;

	logic        download_start;
	logic        download_end;
	nvram_addr_t sd_nv_addr;
	logic        sd_nv_we;

	// ========================================================================
	// SD buffer view of the backup RAM, sector number above byte offset
	// ========================================================================
	assign sd_nv_addr = {sd_lba[5:0], sd_buff_addr};
	assign sd_nv_we   = sd_buff_wr & sd_ack;

	ce_divider u_ce_divider (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader u_cart_loader (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.ioctl_wait     (ioctl_wait),
		.rom_wr_addr    (rom_wr_addr),
		.rom_wr_data    (rom_wr_data),
		.rom_wr_req     (rom_wr_req),
		.rom_wr_ack     (rom_wr_ack),
		.rom_rd_addr    (rom_rd_addr),
		.mem_rd_addr    (mem_rd_addr),
		.gg             (gg),
		.download_start (download_start),
		.download_end   (download_end)
	);

	bk_sync_fsm u_bk_sync_fsm (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.bk_load         (bk_load),
		.bk_save         (bk_save),
		.download_active (ioctl_download),
		.download_start  (download_start),
		.download_end    (download_end),
		.img_mounted     (img_mounted),
		.img_readonly    (img_readonly),
		.img_size        (img_size),
		.sd_lba          (sd_lba),
		.sd_rd           (sd_rd),
		.sd_wr           (sd_wr),
		.sd_ack          (sd_ack),
		.bk_ena          (bk_ena),
		.bk_busy         (bk_busy),
		.bk_loading      (bk_loading)
	);

	nvram_dpram u_nvram_dpram (
		.clk_sys (clk_sys),
		.a_addr  (nvram_a),
		.a_we    (nvram_we),
		.a_d     (nvram_d),
		.a_q     (nvram_q),
		.b_addr  (sd_nv_addr),
		.b_we    (sd_nv_we),
		.b_d     (sd_buff_dout),
		.b_q     (sd_buff_din)
	);

endmodule
